// File: logic/lb_cfg.svh
// ----------------------------------------
// Board control constants
// ----------------------------------------
`ifndef LB_CFG_SVH
`define LB_CFG_SVH

// Bus and field widths
`define LB_ADDR_W        24
`define LB_DATA_W        32
`define LB_CAT_W         4
`define LB_COUNT_W       20
`define LB_DUTY_W        8
`define LB_MISC_W        8
`define LB_FAULT_W       16

// PWM counter, 1024 cycles per period
`define LB_LED_CW        10

// Mirror memory geometry
`define LB_MIRROR_AW     5
`define LB_MIRROR_DEPTH  32

// One counter per packet category
`define LB_RX_DEPTH      16

`define LB_MISC_DEFAULT  8'h00

// Address map, page is addr[23:16]
`define LB_PAGE_REGS     8'h00
`define LB_PAGE_RXCNT    8'h03
`define LB_PAGE_DIRECT   8'h05
`define LB_UNMAPPED      32'hdeadbeef

// Identification words
`define LB_HELLO0        "Hell"
`define LB_HELLO1        "o wo"
`define LB_HELLO2        "rld!"
`define LB_HELLO3        "(::)"

`endif

// File: logic/lb_pkg.sv
// ----------------------------------------
// Local bus types
// ----------------------------------------
`default_nettype none

`include "lb_cfg.svh"

package lb_pkg;

	// Host side of the bus
	typedef logic [`LB_ADDR_W-1:0] lb_addr_t;
	typedef logic [`LB_DATA_W-1:0] lb_data_t;

	// Receive statistics
	typedef logic [`LB_CAT_W-1:0]   rx_cat_t;
	typedef logic [`LB_COUNT_W-1:0] rx_count_t;

	// Direct-write settings
	typedef logic [`LB_DUTY_W-1:0] duty_t;
	typedef logic [`LB_MISC_W-1:0] misc_cfg_t;

	// Word index into the mirror
	typedef logic [`LB_MIRROR_AW-1:0] mirror_addr_t;

endpackage

`default_nettype wire

// File: logic/lb_if.sv
// ----------------------------------------
// Local bus interface
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface lb_if;

	// Host request, straight from the top ports
	lb_pkg::lb_addr_t addr;
	logic             strobe;
	logic             rd;
	lb_pkg::lb_data_t wdata;

	// Write into the direct page, decoded in the core
	logic             local_write;

	// Register core
	modport core (
		input  addr,
		input  strobe,
		input  rd,
		input  wdata,
		output local_write
	);

	// Mirror memory only sees writes and the address
	modport mirror (
		input  addr,
		input  wdata,
		input  local_write
	);

endinterface

`default_nettype wire

// File: logic/rx_category_counter.sv
// ----------------------------------------
// Packet category counters
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "lb_cfg.svh"

module rx_category_counter (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               inc,
	input  lb_pkg::rx_cat_t   cat,
	input  lb_pkg::rx_cat_t   read_addr,
	output lb_pkg::rx_count_t read_data
);

	// One counter per category
	lb_pkg::rx_count_t counts [`LB_RX_DEPTH];

	// ----------------------------------------
	// Increment side
	// ----------------------------------------
	// Wraps at all ones, no saturation
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `LB_RX_DEPTH; i++) begin
				counts[i] <= '0;
			end
		end else if (inc) begin
			counts[cat] <= counts[cat] + 1'b1;
		end
	end

	// ----------------------------------------
	// Read side
	// ----------------------------------------
	// Registered every cycle, lands in read stage 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_data <= '0;
		end else begin
			read_data <= counts[read_addr];
		end
	end

	// Category must be valid on every counted packet
	a_cat_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		inc |-> !$isunknown(cat)
	);

endmodule

`default_nettype wire

// File: logic/mirror_ram.sv
// ----------------------------------------
// Direct-write mirror memory
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "lb_cfg.svh"

module mirror_ram (
	input  wire              clk,
	lb_if.mirror             bus,
	output lb_pkg::lb_data_t rdata
);

	// Storage, contents are undefined until written
	lb_pkg::lb_data_t mem [`LB_MIRROR_DEPTH];

	// Both ports share the low address bits
	lb_pkg::mirror_addr_t word_addr;

	assign word_addr = bus.addr[`LB_MIRROR_AW-1:0];

	// Write port
	// Every direct write is echoed here
	always_ff @(posedge clk) begin
		if (bus.local_write) begin
			mem[word_addr] <= bus.wdata;
		end
	end

	// Read port
	// Follows addr each cycle, core picks it up in stage 2
	always_ff @(posedge clk) begin
		rdata <= mem[word_addr];
	end

endmodule

`default_nettype wire

// File: logic/led_pwm.sv
// ----------------------------------------
// LED PWM and uptime
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "lb_cfg.svh"

module led_pwm (
	input  wire              clk,
	input  wire              rst_n,
	input  lb_pkg::duty_t    duty1,
	input  lb_pkg::duty_t    duty2,
	output logic             led1,
	output logic             led2,
	output lb_pkg::lb_data_t uptime
);

	// Free-running phase counter
	logic [`LB_LED_CW-1:0] led_cc;
	// Carry out, one pulse per wrap
	logic                  led_tick;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cc   <= '0;
			led_tick <= 1'b0;
		end else begin
			{led_tick, led_cc} <= {1'b0, led_cc} + 1'b1;
		end
	end

	// ----------------------------------------
	// Duty comparators
	// ----------------------------------------
	// High for 4*duty counts of each period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led1 <= 1'b0;
			led2 <= 1'b0;
		end else begin
			led1 <= led_cc < {duty1, 2'b00};
			led2 <= led_cc < {duty2, 2'b00};
		end
	end

	// Uptime in PWM periods
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uptime <= '0;
		end else if (led_tick) begin
			uptime <= uptime + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/lb_regs.sv
// ----------------------------------------
// Local bus register core
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "lb_cfg.svh"

module lb_regs (
	input  wire               clk,
	input  wire               rst_n,
	lb_if.core                bus,
	input  wire               fault,
	input  wire [1:0]         rx_buf_status,
	input  lb_pkg::rx_count_t rx_count,
	input  lb_pkg::lb_data_t  mirror_data,
	input  lb_pkg::lb_data_t  uptime,
	output lb_pkg::duty_t     led1_duty,
	output lb_pkg::duty_t     led2_duty,
	output lb_pkg::misc_cfg_t misc_cfg,
	output logic              led_user_mode,
	output lb_pkg::lb_data_t  data_in
);

	// Read request this cycle
	logic do_rd;
	// Direct-write offset
	logic [4:0] wr_offset;

	// Status kept here
	logic [`LB_FAULT_W-1:0] fault_count;
	logic [1:0]             rx_buf_status_r;

	// Pipeline state
	lb_pkg::lb_addr_t addr_r;
	logic             do_rd_r;
	lb_pkg::lb_data_t reg_bank_0;

	assign do_rd     = bus.strobe & bus.rd;
	assign wr_offset = bus.addr[4:0];

	// Writes only land in the direct page
	assign bus.local_write = bus.strobe & ~bus.rd &
		(bus.addr[23:16] == `LB_PAGE_DIRECT);

	// ----------------------------------------
	// Direct-write registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_mode <= 1'b0;
			led1_duty     <= '0;
			led2_duty     <= '0;
			misc_cfg      <= `LB_MISC_DEFAULT;
		end else if (bus.local_write) begin
			case (wr_offset)
				5'd1: led_user_mode <= bus.wdata[0];
				5'd2: led1_duty     <= bus.wdata[`LB_DUTY_W-1:0];
				5'd3: led2_duty     <= bus.wdata[`LB_DUTY_W-1:0];
				5'd4: misc_cfg      <= bus.wdata[`LB_MISC_W-1:0];
				default: ;
			endcase
		end
	end

	// Fault counter
	// Clear by write wins over a fault in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_count <= '0;
		end else if (bus.local_write && wr_offset == 5'd5) begin
			fault_count <= '0;
		end else if (fault) begin
			fault_count <= fault_count + 1'b1;
		end
	end

	// Buffer status into the clk domain
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_buf_status_r <= '0;
		end else begin
			rx_buf_status_r <= rx_buf_status;
		end
	end

	// ----------------------------------------
	// Read stage 1
	// ----------------------------------------
	// Counter and mirror words register in their own modules
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_r  <= '0;
			do_rd_r <= 1'b0;
		end else begin
			addr_r  <= bus.addr;
			do_rd_r <= do_rd;
		end
	end

	// Register bank 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_bank_0 <= '0;
		end else if (do_rd) begin
			case (bus.addr[3:0])
				4'h0: reg_bank_0 <= `LB_HELLO0;
				4'h1: reg_bank_0 <= `LB_HELLO1;
				4'h2: reg_bank_0 <= `LB_HELLO2;
				4'h3: reg_bank_0 <= `LB_HELLO3;
				4'h4: reg_bank_0 <= lb_pkg::lb_data_t'(fault_count);
				4'h6: reg_bank_0 <= lb_pkg::lb_data_t'(rx_buf_status_r);
				4'h8: reg_bank_0 <= uptime;
				default: reg_bank_0 <= `LB_UNMAPPED;
			endcase
		end
	end

	// ----------------------------------------
	// Read stage 2
	// ----------------------------------------
	// Page select, result holds until the next read
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (do_rd_r) begin
			case (addr_r[23:16])
				`LB_PAGE_REGS:   data_in <= reg_bank_0;
				`LB_PAGE_RXCNT:  data_in <= lb_pkg::lb_data_t'(rx_count);
				`LB_PAGE_DIRECT: data_in <= mirror_data;
				default:         data_in <= `LB_UNMAPPED;
			endcase
		end
	end

	// Host must hold strobe at a defined level
	a_strobe_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		!$isunknown(bus.strobe)
	);

endmodule

`default_nettype wire

// File: logic/board_ctrl_top.sv
// ----------------------------------------
// Board housekeeping top
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "lb_cfg.svh"

module board_ctrl_top (
	input  wire               clk,
	input  wire               rst_n,
	// Host bus
	input  lb_pkg::lb_addr_t  addr,
	input  wire               strobe,
	input  wire               rd,
	input  lb_pkg::lb_data_t  wdata,
	output lb_pkg::lb_data_t  data_in,
	// Status inputs
	input  wire               fault,
	input  wire               rx_inc,
	input  lb_pkg::rx_cat_t   rx_cat,
	input  wire [1:0]         rx_buf_status,
	// Board outputs
	output logic              led_user_mode,
	output logic              led1,
	output logic              led2,
	output logic              cfg_d02,
	output logic              mmc_int,
	output logic              allow_mmc_eth_config,
	output logic              zest_pwr_en,
	output logic [3:0]        ext_config
);

	lb_if bus ();

	lb_pkg::rx_count_t rx_count;
	lb_pkg::lb_data_t  mirror_data;
	lb_pkg::lb_data_t  uptime;
	lb_pkg::duty_t     led1_duty;
	lb_pkg::duty_t     led2_duty;
	lb_pkg::misc_cfg_t misc_cfg;

	// Plain ports onto the interface
	assign bus.addr   = addr;
	assign bus.strobe = strobe;
	assign bus.rd     = rd;
	assign bus.wdata  = wdata;

	// Misc byte fans out to the board pins
	assign cfg_d02              = misc_cfg[0];
	assign mmc_int              = misc_cfg[1];
	assign allow_mmc_eth_config = misc_cfg[2];
	assign zest_pwr_en          = misc_cfg[3];
	assign ext_config           = misc_cfg[7:4];

	lb_regs lb_regs_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.bus           (bus.core),
		.fault         (fault),
		.rx_buf_status (rx_buf_status),
		.rx_count      (rx_count),
		.mirror_data   (mirror_data),
		.uptime        (uptime),
		.led1_duty     (led1_duty),
		.led2_duty     (led2_duty),
		.misc_cfg      (misc_cfg),
		.led_user_mode (led_user_mode),
		.data_in       (data_in)
	);

	// Counter read index is the low address nibble
	rx_category_counter rx_category_counter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.inc       (rx_inc),
		.cat       (rx_cat),
		.read_addr (bus.addr[`LB_CAT_W-1:0]),
		.read_data (rx_count)
	);

	mirror_ram mirror_ram_i (
		.clk   (clk),
		.bus   (bus.mirror),
		.rdata (mirror_data)
	);

	led_pwm led_pwm_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.duty1  (led1_duty),
		.duty2  (led2_duty),
		.led1   (led1),
		.led2   (led2),
		.uptime (uptime)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clkgen.sv
// ----------------------------------------
// Testbench clock and reset
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
	output logic clk,
	output logic rst_n
);

	// 4 ns period
	localparam int HALF_NS      = 2;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever #(HALF_NS) clk = ~clk;
	end

	// Release on a rising edge after the reset cycles
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// File: testbench/tb_board_ctrl.sv
// ----------------------------------------
// Board housekeeping testbench
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_board_ctrl;

	// ----------------------------------------
	// Run length
	// ----------------------------------------
	// Rough cycle cost of each test
	localparam int CYC_HELLO  = 60;
	localparam int CYC_MIRROR = 32 * 4 + 32 * 4 + 40;
	localparam int CYC_RX     = 200 + 16 * 4 + 10;
	localparam int CYC_FAULT  = 34 * 2 + 40;
	localparam int CYC_LED    = 4 * (1024 + 12) + 3072 + 20;
	localparam int MARGIN     = 1000;
	localparam int WATCHDOG_NS = 4 * (CYC_HELLO + CYC_MIRROR + CYC_RX + CYC_FAULT +
		CYC_LED + MARGIN);

	logic clk;
	logic rst_n;

	// DUT inputs
	lb_pkg::lb_addr_t  addr;
	logic              strobe;
	logic              rd;
	lb_pkg::lb_data_t  wdata;
	logic              fault;
	logic              rx_inc;
	lb_pkg::rx_cat_t   rx_cat;
	logic [1:0]        rx_buf_status;

	// DUT outputs
	lb_pkg::lb_data_t  data_in;
	logic              led_user_mode;
	logic              led1;
	logic              led2;
	logic              cfg_d02;
	logic              mmc_int;
	logic              allow_mmc_eth_config;
	logic              zest_pwr_en;
	logic [3:0]        ext_config;

	// Bookkeeping
	string            cur_test;
	int               err_count  = 0;
	int               pass_tests = 0;
	int               fail_tests = 0;
	lb_pkg::lb_data_t seed       = 32'h8b6;

	// Read burst scratch
	lb_pkg::lb_addr_t burst_addr [16];
	lb_pkg::lb_data_t burst_data [16];

	tb_clkgen clkgen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	board_ctrl_top board_ctrl_top_i (
		.clk                  (clk),
		.rst_n                (rst_n),
		.addr                 (addr),
		.strobe               (strobe),
		.rd                   (rd),
		.wdata                (wdata),
		.data_in              (data_in),
		.fault                (fault),
		.rx_inc               (rx_inc),
		.rx_cat               (rx_cat),
		.rx_buf_status        (rx_buf_status),
		.led_user_mode        (led_user_mode),
		.led1                 (led1),
		.led2                 (led2),
		.cfg_d02              (cfg_d02),
		.mmc_int              (mmc_int),
		.allow_mmc_eth_config (allow_mmc_eth_config),
		.zest_pwr_en          (zest_pwr_en),
		.ext_config           (ext_config)
	);

	// Linear congruential generator
	function automatic lb_pkg::lb_data_t next_random();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// ----------------------------------------
	// Compare and report
	// ----------------------------------------
	task automatic check_data(input string what, input lb_pkg::lb_data_t exp,
		input lb_pkg::lb_data_t act);
		if (act !== exp) begin
			err_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_count(input string what, input lb_pkg::rx_count_t exp,
		input lb_pkg::rx_count_t act);
		if (act !== exp) begin
			err_count++;
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			err_count++;
			$display("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic finish_test(input int errs_before);
		if (err_count == errs_before) begin
			pass_tests++;
			$display("%s: ok", cur_test);
		end else begin
			fail_tests++;
			$display("%s: %0d mismatches", cur_test, err_count - errs_before);
		end
	endtask

	// Misc byte as the board pins show it
	function automatic lb_pkg::lb_data_t pins_word();
		return {24'h0, ext_config, zest_pwr_en, allow_mmc_eth_config, mmc_int, cfg_d02};
	endfunction

	// ----------------------------------------
	// Bus driver
	// ----------------------------------------
	// One read per cycle with results two edges behind
	task automatic read_burst(input int n);
		for (int i = 0; i < n + 2; i++) begin
			@(posedge clk);
			if (i < n) begin
				addr   <= burst_addr[i];
				strobe <= 1'b1;
				rd     <= 1'b1;
			end else begin
				strobe <= 1'b0;
				rd     <= 1'b0;
			end
			@(negedge clk);
			if (i >= 2) begin
				burst_data[i - 2] = data_in;
			end
		end
	endtask

	task automatic bus_read(input lb_pkg::lb_addr_t a, output lb_pkg::lb_data_t d);
		burst_addr[0] = a;
		read_burst(1);
		d = burst_data[0];
	endtask

	// Returns once the written register shows its new value
	task automatic bus_write(input lb_pkg::lb_addr_t a, input lb_pkg::lb_data_t d);
		@(posedge clk);
		addr   <= a;
		wdata  <= d;
		strobe <= 1'b1;
		rd     <= 1'b0;
		@(posedge clk);
		strobe <= 1'b0;
		@(negedge clk);
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic test_hello();
		lb_pkg::lb_data_t hello [4];
		lb_pkg::lb_data_t exp   [5];
		lb_pkg::lb_data_t got;
		int               errs;
		errs = err_count;
		cur_test = "hello_regs";
		// ASCII "Hell", "o wo", "rld!", "(::)"
		hello = '{32'h48656c6c, 32'h6f20776f, 32'h726c6421, 32'h283a3a29};
		check_data("data_in after reset", '0, data_in);
		check_bit("led_user_mode after reset", 1'b0, led_user_mode);
		check_bit("led1 after reset", 1'b0, led1);
		check_bit("led2 after reset", 1'b0, led2);
		check_data("pins after reset", 32'h0, pins_word());
		for (int i = 0; i < 4; i++) begin
			bus_read(24'(i), got);
			check_data($sformatf("offset %0d", i), hello[i], got);
		end
		bus_read(24'h070000, got);
		check_data("unmapped page", 32'hdeadbeef, got);
		// Mixed order at one read per cycle
		burst_addr[0] = 24'h000003;
		burst_addr[1] = 24'h000002;
		burst_addr[2] = 24'h070000;
		burst_addr[3] = 24'h000001;
		burst_addr[4] = 24'h000000;
		exp = '{hello[3], hello[2], 32'hdeadbeef, hello[1], hello[0]};
		read_burst(5);
		for (int i = 0; i < 5; i++) begin
			check_data($sformatf("burst %0d", i), exp[i], burst_data[i]);
		end
		finish_test(errs);
	endtask

	task automatic test_mirror();
		lb_pkg::lb_data_t mirror_model [32];
		lb_pkg::lb_data_t got;
		lb_pkg::lb_data_t v;
		int               errs;
		errs = err_count;
		cur_test = "mirror_page";
		for (int i = 0; i < 32; i++) begin
			v = next_random();
			mirror_model[i] = v;
			bus_write(24'h050000 + 24'(i), v);
		end
		for (int i = 0; i < 32; i++) begin
			bus_read(24'h050000 + 24'(i), got);
			check_data($sformatf("mirror %0d", i), mirror_model[i], got);
		end
		// Misc byte onto the pins
		for (int k = 0; k < 3; k++) begin
			v = next_random();
			bus_write(24'h050004, v);
			check_data("misc pins", {24'h0, v[7:0]}, pins_word());
		end
		bus_write(24'h050001, 32'h1);
		check_bit("led_user_mode set", 1'b1, led_user_mode);
		bus_write(24'h050001, 32'h0);
		check_bit("led_user_mode clear", 1'b0, led_user_mode);
		finish_test(errs);
	endtask

	task automatic test_rx_counts();
		lb_pkg::rx_count_t rx_model [16];
		lb_pkg::rx_cat_t   c;
		lb_pkg::lb_data_t  got;
		int                errs;
		errs = err_count;
		cur_test = "rx_counters";
		for (int i = 0; i < 16; i++) begin
			rx_model[i] = '0;
		end
		// Top bits of the LCG pick the category
		for (int n = 0; n < 200; n++) begin
			c = lb_pkg::rx_cat_t'(next_random() >> 28);
			@(posedge clk);
			rx_inc <= 1'b1;
			rx_cat <= c;
			rx_model[c] = rx_model[c] + 1'b1;
		end
		@(posedge clk);
		rx_inc <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			bus_read(24'h030000 + 24'(i), got);
			check_count($sformatf("category %0d", i), rx_model[i],
				lb_pkg::rx_count_t'(got));
		end
		finish_test(errs);
	endtask

	task automatic test_fault_status();
		lb_pkg::lb_data_t got;
		int               pulses;
		int               errs;
		errs = err_count;
		cur_test = "fault_status";
		bus_write(24'h050005, 32'h0);
		pulses = 3 + int'(next_random() >> 27);
		for (int p = 0; p < pulses; p++) begin
			@(posedge clk);
			fault <= 1'b1;
			@(posedge clk);
			fault <= 1'b0;
		end
		bus_read(24'h000004, got);
		check_data("fault count", lb_pkg::lb_data_t'(pulses), got);
		bus_write(24'h050005, 32'h0);
		bus_read(24'h000004, got);
		check_data("fault count cleared", 32'h0, got);
		// Status passes one sync register
		for (int s = 1; s < 4; s++) begin
			@(posedge clk);
			rx_buf_status <= 2'(s);
			bus_read(24'h000006, got);
			check_data($sformatf("rx_buf_status %0d", s), lb_pkg::lb_data_t'(s), got);
		end
		finish_test(errs);
	endtask

	task automatic test_led_uptime();
		int               duties [4];
		int               d1;
		int               d2;
		int               on1;
		int               on2;
		lb_pkg::lb_data_t up1;
		lb_pkg::lb_data_t up2;
		int               errs;
		errs = err_count;
		cur_test = "led_uptime";
		duties = '{0, 1, 100, 255};
		for (int k = 0; k < 4; k++) begin
			d1 = duties[k];
			d2 = duties[3 - k];
			bus_write(24'h050002, lb_pkg::lb_data_t'(d1));
			bus_write(24'h050003, lb_pkg::lb_data_t'(d2));
			// Comparator is one register behind the duty
			repeat (2) @(posedge clk);
			on1 = 0;
			on2 = 0;
			// One full PWM period
			repeat (1024) begin
				@(negedge clk);
				on1 += int'(led1);
				on2 += int'(led2);
			end
			check_data($sformatf("led1 duty %0d", d1), lb_pkg::lb_data_t'(4 * d1),
				lb_pkg::lb_data_t'(on1));
			check_data($sformatf("led2 duty %0d", d2), lb_pkg::lb_data_t'(4 * d2),
				lb_pkg::lb_data_t'(on2));
		end
		// Second read issued 3072 edges after the first
		bus_read(24'h000008, up1);
		repeat (3069) @(posedge clk);
		bus_read(24'h000008, up2);
		check_data("uptime over 3072 cycles", 32'd3, up2 - up1);
		finish_test(errs);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		addr          = '0;
		strobe        = 1'b0;
		rd            = 1'b0;
		wdata         = '0;
		fault         = 1'b0;
		rx_inc        = 1'b0;
		rx_cat        = '0;
		rx_buf_status = 2'b00;
		wait (rst_n === 1'b1);
		@(negedge clk);
		test_hello();
		test_mirror();
		test_rx_counts();
		test_fault_status();
		test_led_uptime();
		$display("Tests passed %0d, failed %0d, mismatches %0d",
			pass_tests, fail_tests, err_count);
		if (err_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, tests still running after %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/lb_pkg.sv
logic/lb_if.sv
logic/rx_category_counter.sv
logic/mirror_ram.sv
logic/led_pwm.sv
logic/lb_regs.sv
logic/board_ctrl_top.sv
testbench/tb_clkgen.sv
testbench/tb_board_ctrl.sv

// File: Makefile
# Verilator build and run for the board housekeeping testbench

VERILATOR  ?= verilator
TOP        ?= tb_board_ctrl
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, the simulator status is not trusted
run: build
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q '>>> PASS' $(LOG); then echo "No result in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
